// ==== logic/i3c_tx_defs.svh ====
// I3C target transmit path widths, SCL synchronizer depth and stable-low threshold
`ifndef I3C_TX_DEFS_SVH
`define I3C_TX_DEFS_SVH

// Width of the timing counters and of the timing inputs
`define I3C_TCOUNT_W 20

// One data byte on the bus
`define I3C_BYTE_W 8

// Flip-flops between scl_i and the edge detector
`define I3C_SYNC_STAGES 2

// Cycles of synchronized SCL low before the low phase counts as stable
`define I3C_STABLE_LOW 4

`endif

// ==== logic/i3c_tx_pkg.sv ====
// I3C target transmit path types: bus timing struct and FSM state encodings
`include "i3c_tx_defs.svh"

package i3c_tx_pkg;

  // Bus timings in clock cycles
  typedef struct packed {
    logic [`I3C_TCOUNT_W-1:0] t_r;       // SDA/SCL rise time
    logic [`I3C_TCOUNT_W-1:0] t_su_dat;  // Data setup before SCL rise
    logic [`I3C_TCOUNT_W-1:0] t_hd_dat;  // Data hold after SCL fall
  } i3c_timing_t;

  // Bit driver states
  typedef enum logic [2:0] {
    Idle,
    AwaitClockNegedge,
    SetupData,
    TransmitData,
    HoldData
  } tx_state_e;

  // What the bit driver's delay counter is loaded with
  typedef enum logic [1:0] {
    tSetupData,
    tHoldData,
    tNoDelay
  } tcount_sel_e;

  // Byte serializer states
  typedef enum logic [1:0] {
    WaitReq,
    Shift,
    WaitReqLow
  } flow_state_e;

endpackage

// ==== logic/i3c_bit_if.sv ====
// Bit request and status link between the byte serializer and the SDA bit driver
`timescale 1ns/1ps

interface i3c_bit_if;

  // Serializer side
  logic drive;        // Bit request, held until tx_done
  logic drive_value;  // Bit to put on SDA
  logic sel_od_pp;    // 1 selects push-pull, 0 open drain

  // Bit driver side
  logic tx_done;      // One-cycle pulse when the bit is finished
  logic tx_idle;

  modport flow (
    output drive,
    output drive_value,
    output sel_od_pp,
    input  tx_done,
    input  tx_idle
  );

  modport tx (
    input  drive,
    input  drive_value,
    input  sel_od_pp,
    output tx_done,
    output tx_idle
  );

endinterface

// ==== logic/scl_monitor.sv ====
// SCL monitor: synchronizes SCL and reports its edges and a stable low phase
`timescale 1ns/1ps
`include "i3c_tx_defs.svh"

module scl_monitor (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  output logic scl_negedge_o,
  output logic scl_posedge_o,
  output logic scl_stable_low_o
);

  localparam int unsigned LowCntW = $clog2(`I3C_STABLE_LOW + 1);
  localparam logic [LowCntW-1:0] LowThresh = LowCntW'(`I3C_STABLE_LOW);

  logic [`I3C_SYNC_STAGES-1:0] sync_q;
  logic                        scl_s;       // Synchronized SCL
  logic                        scl_prev_q;
  logic                        negedge_q;
  logic                        posedge_q;
  logic [LowCntW-1:0]          low_cnt_q;

  assign scl_s = sync_q[`I3C_SYNC_STAGES-1];

  // Bus idles with SCL high, so the chain resets to ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q     <= '1;
      scl_prev_q <= 1'b1;
      negedge_q  <= 1'b0;
      posedge_q  <= 1'b0;
    end else begin
      sync_q     <= {sync_q[`I3C_SYNC_STAGES-2:0], scl_i};
      scl_prev_q <= scl_s;
      negedge_q  <= scl_prev_q & ~scl_s;
      posedge_q  <= ~scl_prev_q & scl_s;
    end
  end

  // Counts low cycles and saturates at the threshold
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      low_cnt_q <= '0;
    end else if (scl_s) begin
      low_cnt_q <= '0;
    end else if (low_cnt_q != LowThresh) begin
      low_cnt_q <= low_cnt_q + 1'b1;
    end
  end

  assign scl_negedge_o    = negedge_q;
  assign scl_posedge_o    = posedge_q;
  assign scl_stable_low_o = (low_cnt_q == LowThresh);  // Drops with the posedge pulse

  a_edges_exclusive : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(scl_negedge_o && scl_posedge_o)
  );

endmodule

// ==== logic/bus_tx.sv ====
// I3C target bit driver: places one bit on SDA with setup and hold timing against SCL
`timescale 1ns/1ps
`include "i3c_tx_defs.svh"

module bus_tx (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  i3c_tx_pkg::i3c_timing_t  timing_i,
  i3c_bit_if.tx                    bit_if,
  input  logic                     scl_negedge_i,
  input  logic                     scl_posedge_i,
  input  logic                     scl_stable_low_i,
  output logic                     sel_od_pp_o,
  output logic                     sda_o
);

  localparam int unsigned TW = `I3C_TCOUNT_W;

  i3c_tx_pkg::tx_state_e   state_q, state_d;
  i3c_tx_pkg::tcount_sel_e tcount_sel;

  logic [TW-1:0] tcount_q;
  logic [TW-1:0] tcount_d;
  logic          load_tcount;

  logic [TW-1:0] t_sd;        // Rise plus setup
  logic [TW-1:0] t_sd_q;
  logic          t_sd_z_q;
  logic          t_hd_z_q;

  logic          sel_q;
  logic          sda;
  logic          tx_done;
  logic          scl_low_evt;  // SCL is in a phase where data may change
  logic          setup_done;

  assign t_sd        = timing_i.t_r + timing_i.t_su_dat;
  assign scl_low_evt = scl_stable_low_i | scl_negedge_i;
  // A rising SCL ends the setup window even if the count is not through
  assign setup_done  = (tcount_q == TW'(1)) | scl_posedge_i;

  always_ff @(posedge clk_i) begin
    t_sd_q   <= t_sd;
    t_sd_z_q <= (t_sd == '0);
    t_hd_z_q <= (timing_i.t_hd_dat == '0);
  end

  // Delay counter, loaded on request and free running down to zero
  always_comb begin
    tcount_d = tcount_q;
    if (load_tcount) begin
      unique case (tcount_sel)
        i3c_tx_pkg::tSetupData: tcount_d = t_sd_q;
        i3c_tx_pkg::tHoldData:  tcount_d = t_hd_z_q ? TW'(1) : timing_i.t_hd_dat;
        default:                tcount_d = TW'(1);
      endcase
    end else if (tcount_q != '0) begin
      tcount_d = tcount_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tcount_q <= '0;
      state_q  <= i3c_tx_pkg::Idle;
    end else begin
      tcount_q <= tcount_d;
      state_q  <= state_d;
    end
  end

  // OD/PP choice follows the bit that was accepted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= 1'b0;
    end else if (state_q == i3c_tx_pkg::Idle && bit_if.drive) begin
      sel_q <= bit_if.sel_od_pp;
    end
  end

  always_comb begin
    sda         = 1'b1;  // Released unless a state drives it
    tx_done     = 1'b0;
    load_tcount = 1'b0;
    tcount_sel  = i3c_tx_pkg::tNoDelay;
    unique case (state_q)
      i3c_tx_pkg::Idle: begin
        if (bit_if.drive) begin
          tcount_sel  = i3c_tx_pkg::tSetupData;
          load_tcount = 1'b1;
          if (t_sd_z_q && scl_low_evt) sda = bit_if.drive_value;
        end
      end
      i3c_tx_pkg::AwaitClockNegedge: begin
        tcount_sel  = i3c_tx_pkg::tSetupData;
        load_tcount = 1'b1;  // Reloaded every cycle until SCL goes low
        if (t_sd_z_q && scl_low_evt) sda = bit_if.drive_value;
      end
      i3c_tx_pkg::SetupData: begin
        if (setup_done) sda = bit_if.drive_value;
      end
      i3c_tx_pkg::TransmitData: begin
        sda = bit_if.drive_value;
        if (scl_negedge_i) begin
          tcount_sel  = i3c_tx_pkg::tHoldData;
          load_tcount = 1'b1;
          tx_done     = t_hd_z_q;
        end
      end
      i3c_tx_pkg::HoldData: begin
        if (tcount_q != '0) begin
          sda = bit_if.drive_value;
        end else if (scl_stable_low_i) begin
          tx_done = 1'b1;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      i3c_tx_pkg::Idle: begin
        if (bit_if.drive) begin
          if (scl_low_evt) begin
            state_d = t_sd_z_q ? i3c_tx_pkg::TransmitData : i3c_tx_pkg::SetupData;
          end else begin
            state_d = i3c_tx_pkg::AwaitClockNegedge;
          end
        end
      end
      i3c_tx_pkg::AwaitClockNegedge: begin
        if (scl_low_evt) begin
          state_d = t_sd_z_q ? i3c_tx_pkg::TransmitData : i3c_tx_pkg::SetupData;
        end
      end
      i3c_tx_pkg::SetupData: begin
        if (setup_done) state_d = i3c_tx_pkg::TransmitData;
      end
      i3c_tx_pkg::TransmitData: begin
        if (scl_negedge_i) begin
          state_d = t_hd_z_q ? i3c_tx_pkg::Idle : i3c_tx_pkg::HoldData;
        end
      end
      i3c_tx_pkg::HoldData: begin
        if (tcount_q == '0 && scl_stable_low_i) state_d = i3c_tx_pkg::Idle;
      end
      default: state_d = i3c_tx_pkg::Idle;
    endcase
  end

  assign sda_o          = sda;
  assign sel_od_pp_o    = sel_q;
  assign bit_if.tx_done = tx_done;
  assign bit_if.tx_idle = (state_q == i3c_tx_pkg::Idle);

  a_no_done_in_idle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(state_q == i3c_tx_pkg::Idle && tx_done)
  );

  // The serializer must not move a bit before the driver is through with it
  a_bit_held_until_done : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (bit_if.drive && !tx_done) |=> (bit_if.drive && $stable(bit_if.drive_value))
  );

endmodule

// ==== logic/byte_tx_flow.sv ====
// I3C target byte serializer: req/ack byte intake, MSB-first bits and T-bit
`timescale 1ns/1ps
`include "i3c_tx_defs.svh"

module byte_tx_flow (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   data_req_i,
  input  logic                   last_i,
  input  logic [`I3C_BYTE_W-1:0] byte_i,
  output logic                   data_ack_o,
  i3c_bit_if.flow                bit_if
);

  localparam int unsigned CntW = $clog2(`I3C_BYTE_W + 1);
  localparam logic [CntW-1:0] TBitIdx = CntW'(`I3C_BYTE_W);

  i3c_tx_pkg::flow_state_e state_q, state_d;

  logic [`I3C_BYTE_W-1:0] shift_q;
  logic                   last_q;
  logic [CntW-1:0]        bit_cnt_q;
  logic                   ack_q;
  logic                   accept;
  logic                   tbit;      // Ninth bit of the byte
  logic                   advance;

  assign accept  = (state_q == i3c_tx_pkg::WaitReq) && data_req_i;
  assign tbit    = (bit_cnt_q == TBitIdx);
  assign advance = (state_q == i3c_tx_pkg::Shift) && bit_if.tx_done && !tbit;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      i3c_tx_pkg::WaitReq: begin
        if (data_req_i) state_d = i3c_tx_pkg::Shift;
      end
      i3c_tx_pkg::Shift: begin
        if (bit_if.tx_done && tbit) state_d = i3c_tx_pkg::WaitReqLow;
      end
      i3c_tx_pkg::WaitReqLow: begin
        // Handshake has to be back at rest before the next byte
        if (!ack_q && !data_req_i) state_d = i3c_tx_pkg::WaitReq;
      end
      default: state_d = i3c_tx_pkg::WaitReq;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= i3c_tx_pkg::WaitReq;
      ack_q     <= 1'b0;
      bit_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        ack_q <= 1'b1;
      end else if (!data_req_i) begin
        ack_q <= 1'b0;  // Host released req
      end
      if (accept) begin
        bit_cnt_q <= '0;
      end else if (advance) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_q <= byte_i;
      last_q  <= last_i;
    end else if (advance) begin
      shift_q <= {shift_q[`I3C_BYTE_W-2:0], 1'b0};
    end
  end

  assign data_ack_o         = ack_q;
  assign bit_if.drive       = (state_q == i3c_tx_pkg::Shift);
  assign bit_if.drive_value = tbit ? ~last_q : shift_q[`I3C_BYTE_W-1];  // T-bit is 1 if more follow
  assign bit_if.sel_od_pp   = ~tbit;  // Push-pull for data, open drain for T-bit

  a_ack_held_while_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (data_ack_o && data_req_i) |=> data_ack_o
  );

endmodule

// ==== logic/i3c_target_tx.sv ====
// I3C target SDR transmit path: SCL monitor, byte serializer and SDA bit driver
`timescale 1ns/1ps
`include "i3c_tx_defs.svh"

module i3c_target_tx (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     scl_i,
  input  logic [`I3C_TCOUNT_W-1:0] t_r_i,
  input  logic [`I3C_TCOUNT_W-1:0] t_su_dat_i,
  input  logic [`I3C_TCOUNT_W-1:0] t_hd_dat_i,
  input  logic                     data_req_i,
  input  logic                     last_i,
  input  logic [`I3C_BYTE_W-1:0]   byte_i,
  output logic                     data_ack_o,
  output logic                     sda_o,
  output logic                     sel_od_pp_o,
  output logic                     tx_idle_o
);

  i3c_tx_pkg::i3c_timing_t timing;

  logic scl_negedge;
  logic scl_posedge;
  logic scl_stable_low;

  i3c_bit_if bit_if ();

  assign timing.t_r      = t_r_i;
  assign timing.t_su_dat = t_su_dat_i;
  assign timing.t_hd_dat = t_hd_dat_i;

  scl_monitor u_scl_monitor (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .scl_i            (scl_i),
    .scl_negedge_o    (scl_negedge),
    .scl_posedge_o    (scl_posedge),
    .scl_stable_low_o (scl_stable_low)
  );

  byte_tx_flow u_byte_tx_flow (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .data_req_i (data_req_i),
    .last_i     (last_i),
    .byte_i     (byte_i),
    .data_ack_o (data_ack_o),
    .bit_if     (bit_if.flow)
  );

  bus_tx u_bus_tx (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .timing_i         (timing),
    .bit_if           (bit_if.tx),
    .scl_negedge_i    (scl_negedge),
    .scl_posedge_i    (scl_posedge),
    .scl_stable_low_i (scl_stable_low),
    .sel_od_pp_o      (sel_od_pp_o),
    .sda_o            (sda_o)
  );

  assign tx_idle_o = bit_if.tx_idle;

endmodule

// ==== test/tb_i3c_target_tx.sv ====
// Testbench for the I3C target transmit path with an SCL controller model and a byte host
`timescale 1ns/1ps
`include "i3c_tx_defs.svh"

module tb_i3c_target_tx;

  localparam int CLK_PERIOD = 10;
  localparam int HIGH_CYC   = 8;   // SCL high period in clock cycles
  localparam int ACK_WAIT   = 20;  // Cycles allowed for each ack transition

  logic                     clk_i;
  logic                     rst_ni;
  logic                     scl_i;
  logic [`I3C_TCOUNT_W-1:0] t_r_i;
  logic [`I3C_TCOUNT_W-1:0] t_su_dat_i;
  logic [`I3C_TCOUNT_W-1:0] t_hd_dat_i;
  logic                     data_req_i;
  logic                     last_i;
  logic [`I3C_BYTE_W-1:0]   byte_i;
  logic                     data_ack_o;
  logic                     sda_o;
  logic                     sel_od_pp_o;
  logic                     tx_idle_o;

  logic  capture_en;
  logic  sda_seen[$];  // Samples taken at SCL rising edges
  logic  sel_seen[$];
  string cur_test;
  int    n_tests;
  int    n_checks;
  int    n_errors;
  int    errors_at_start;

  i3c_target_tx u_i3c_target_tx (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .scl_i       (scl_i),
    .t_r_i       (t_r_i),
    .t_su_dat_i  (t_su_dat_i),
    .t_hd_dat_i  (t_hd_dat_i),
    .data_req_i  (data_req_i),
    .last_i      (last_i),
    .byte_i      (byte_i),
    .data_ack_o  (data_ack_o),
    .sda_o       (sda_o),
    .sel_od_pp_o (sel_od_pp_o),
    .tx_idle_o   (tx_idle_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Controller samples SDA on the rising SCL edge
  always @(posedge scl_i) begin
    if (capture_en) begin
      sda_seen.push_back(sda_o);
      sel_seen.push_back(sel_od_pp_o);
    end
  end

  // Low phase long enough for hold, stable-low detection and setup
  function automatic int low_cycles(input int tr, input int tsu, input int thd);
    return tr + tsu + thd + `I3C_STABLE_LOW + 8;
  endfunction

  function automatic int byte_cycles(input int low);
    return 10 * (low + HIGH_CYC + 2) + 20;  // Ten SCL periods plus handshake
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("ERR %s (%s) expected %0h actual %0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    n_errors++;
    $display("%s: %s", cur_test, what);
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = n_errors;
  endtask

  task automatic end_test();
    n_tests++;
    if (n_errors == errors_at_start) $display("%s: ok", cur_test);
    else $display("%s: %0d error(s)", cur_test, n_errors - errors_at_start);
  endtask

  task automatic set_timing(input int tr, input int tsu, input int thd);
    @(posedge clk_i);
    #1;
    t_r_i      = tr;
    t_su_dat_i = tsu;
    t_hd_dat_i = thd;
    repeat (2) @(posedge clk_i);  // Let the bit driver register the new sums
  endtask

  // SCL controller model with nbits full periods and one closing fall that ends the last bit
  // Expected SDA sequence comes in bits with the first bit in the MSB
  task automatic clock_bits(input int nbits, input int low, input int hold,
                            input logic [8:0] bits);
    for (int i = 0; i <= nbits; i++) begin
      @(posedge clk_i);
      #1 scl_i = 1'b0;
      for (int j = 1; j <= low; j++) begin
        @(posedge clk_i);
        #1;
        if (i > 0 && j <= hold) begin  // First fall of a run ends no bit
          check_value($sformatf("hold after fall %0d cycle %0d", i, j), bits[9 - i], sda_o);
        end
      end
      capture_en = (i < nbits);
      scl_i      = 1'b1;
      repeat (HIGH_CYC) @(posedge clk_i);
    end
    capture_en = 1'b0;
  endtask

  // Host side of the four-phase handshake
  task automatic send_byte(input logic [7:0] b, input logic last, input int req_hold);
    int n;
    @(posedge clk_i);
    #1;
    check_value("ack low before req", 1'b0, data_ack_o);
    byte_i     = b;
    last_i     = last;
    data_req_i = 1'b1;
    @(negedge clk_i);
    check_value("ack before req seen", 1'b0, data_ack_o);
    n = 0;
    while (!data_ack_o && n < ACK_WAIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!data_ack_o) report_failure("data_ack_o never rose after data_req_i");
    for (int k = 0; k < req_hold; k++) begin
      @(negedge clk_i);
      check_value("ack held while req high", 1'b1, data_ack_o);
    end
    @(posedge clk_i);
    #1 data_req_i = 1'b0;
    n = 0;
    while (data_ack_o && n < ACK_WAIT) begin
      @(negedge clk_i);
      n++;
    end
    if (data_ack_o) report_failure("data_ack_o stayed high after data_req_i fell");
  endtask

  task automatic transfer_byte(input logic [7:0] b, input logic last, input int req_hold);
    int         low;
    logic [8:0] exp_bits;
    low      = low_cycles(t_r_i, t_su_dat_i, t_hd_dat_i);
    exp_bits = {b, ~last};  // MSB first and a T-bit that is set if more follow
    sda_seen.delete();
    sel_seen.delete();
    send_byte(b, last, req_hold);
    clock_bits(9, low, t_hd_dat_i, exp_bits);
    for (int k = 0; k < 9; k++) begin
      check_value($sformatf("byte %02h bit %0d sda", b, k), exp_bits[8 - k], sda_seen[k]);
      check_value($sformatf("byte %02h bit %0d od/pp", b, k), k < 8, sel_seen[k]);
    end
    check_value("sda released after byte", 1'b1, sda_o);
    check_value("open drain after byte", 1'b0, sel_od_pp_o);
    check_value("idle after byte", 1'b1, tx_idle_o);
  endtask

  task automatic test_reset_idle();
    begin_test("reset_idle");
    check_value("sda after reset", 1'b1, sda_o);
    check_value("od/pp after reset", 1'b0, sel_od_pp_o);
    check_value("idle after reset", 1'b1, tx_idle_o);
    check_value("ack after reset", 1'b0, data_ack_o);
    sda_seen.delete();
    sel_seen.delete();
    clock_bits(2, low_cycles(0, 0, 0), 0, 9'h1ff);  // SCL runs with no byte pending
    foreach (sda_seen[k]) begin
      check_value("sda without request", 1'b1, sda_seen[k]);
      check_value("od/pp without request", 1'b0, sel_seen[k]);
    end
    check_value("idle without request", 1'b1, tx_idle_o);
    end_test();
  endtask

  task automatic test_single_byte();
    begin_test("single_byte");
    set_timing(1, 2, 2);
    transfer_byte(8'ha5, 1'b1, 1);
    end_test();
  endtask

  task automatic test_random_bytes();
    logic [31:0] rnd;
    begin_test("random_bytes");
    for (int i = 0; i < 3; i++) begin
      rnd = $urandom();
      transfer_byte(rnd[7:0], i == 2, 1);
    end
    end_test();
  endtask

  task automatic test_handshake();
    begin_test("handshake");
    transfer_byte(8'h5a, 1'b1, 6);  // Host keeps req up well past the ack
    end_test();
  endtask

  task automatic test_hold_timing();
    begin_test("hold_timing");
    set_timing(0, 0, 0);
    transfer_byte(8'hc3, 1'b1, 1);
    set_timing(1, 1, 6);
    transfer_byte(8'h96, 1'b1, 1);
    end_test();
  endtask

  task automatic test_setup_timing();
    begin_test("setup_timing");
    set_timing(6, 10, 3);
    transfer_byte(8'h3c, 1'b1, 1);
    end_test();
  endtask

  initial begin : watchdog
    int budget;
    budget = 10 + 3 * (low_cycles(0, 0, 0) + HIGH_CYC + 2);
    budget += 5 * byte_cycles(low_cycles(1, 2, 2));
    budget += byte_cycles(low_cycles(0, 0, 0)) + byte_cycles(low_cycles(1, 1, 6));
    budget += byte_cycles(low_cycles(6, 10, 3));
    #(2 * budget * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d clock cycles", 2 * budget);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : main
    rst_ni     = 1'b0;
    scl_i      = 1'b1;  // Bus idle
    t_r_i      = '0;
    t_su_dat_i = '0;
    t_hd_dat_i = '0;
    data_req_i = 1'b0;
    last_i     = 1'b0;
    byte_i     = '0;
    capture_en = 1'b0;
    n_tests    = 0;
    n_checks   = 0;
    n_errors   = 0;
    void'($urandom(32'h63a0));
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    test_reset_idle();
    test_single_byte();
    test_random_bytes();
    test_handshake();
    test_hold_timing();
    test_setup_timing();
    $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== i3c_target_tx.f ====
+incdir+logic
logic/i3c_tx_pkg.sv
logic/i3c_bit_if.sv
logic/scl_monitor.sv
logic/bus_tx.sv
logic/byte_tx_flow.sv
logic/i3c_target_tx.sv
test/tb_i3c_target_tx.sv

// ==== Bender.yml ====
package:
  name: i3c_target_tx

sources:
  - include_dirs:
      - logic
    files:
      - logic/i3c_tx_pkg.sv
      - logic/i3c_bit_if.sv
      - logic/scl_monitor.sv
      - logic/bus_tx.sv
      - logic/byte_tx_flow.sv
      - logic/i3c_target_tx.sv

  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_i3c_target_tx.sv
